/* compile.f */
design/l1_pkg.sv
design/cache_array.sv
design/byte_lanes.sv
design/snoop_ctrl.sv
design/core_ctrl.sv
design/l1_cache_top.sv
bench/tb_l1_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the L1 cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_l1_cache -o sim_l1_cache

output=$(./obj_dir/sim_l1_cache 2>&1)
echo "$output"

if grep -qx "Simulation passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* bench/tb_l1_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_l1_cache
    import l1_pkg::*;
();

    localparam logic [31:0] SEED     = 32'h8ffdfcc4;
    localparam opcode_t     OPC_NONE = 7'b0010011;   // Not a memory access
    localparam int          RUN_MAX  = 20000;

    logic    clk;
    logic    reset;
    opcode_t opcode_in;
    mask_t   mask_in;
    addr_t   address_in;
    word_t   data_in;
    word_t   data_out;
    logic    stall;
    logic    req_core;
    logic    grant;
    word_t   bus_data_in;
    logic    cache_hit_in;
    bus_op_e bus_operation_in;
    addr_t   bus_address_in;
    bus_op_e bus_operation_out;
    addr_t   bus_address_out;
    word_t   bus_data_out;
    logic    cache_hit_out;
    logic    flush_out;

    // Check enables and expected values driven with the stimulus
    logic    chk_idle;
    logic    chk_wait;
    logic    chk_op;
    logic    chk_load;
    logic    chk_no_stall;
    logic    chk_snoop;
    bus_op_e exp_op;
    addr_t   exp_addr;
    word_t   exp_load;
    logic    exp_hit;
    logic    exp_flush;
    word_t   exp_snoop_data;

    // Shadow of the line array
    mesi_e sh_state [NUM_LINES];
    tag_t  sh_tag   [NUM_LINES];
    word_t sh_data  [NUM_LINES];

    string test_name;
    int    errors;
    int    errors_at_start;
    int    tests;
    int    failed;

    l1_cache_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        for (int n = 0; n < RUN_MAX; n++) begin
            @(posedge clk);
        end
        $display("Run did not finish within %0d cycles", RUN_MAX);
        $display("Simulation failed");
        $finish;
    end

    // Memory content for words no cache has supplied
    function automatic word_t mem_word(input addr_t addr);
        addr_t a;
        a = {addr[31:2], 2'b00};
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1);
    endfunction

    function automatic word_t load_field(input word_t w, input mask_t m, input offset_t off);
        word_t sh;
        sh = w >> (8 * off);
        case (m)
            MASK_B:  return {{24{sh[7]}}, sh[7:0]};
            MASK_BU: return {24'h0, sh[7:0]};
            MASK_H:  return {{16{sh[15]}}, sh[15:0]};
            MASK_HU: return {16'h0, sh[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic word_t merge_store(input word_t base, input word_t d, input mask_t m,
                                          input offset_t off);
        word_t lanes;
        case (m)
            MASK_B, MASK_BU: lanes = 32'h0000_00ff << (8 * off);
            MASK_H, MASK_HU: lanes = 32'h0000_ffff << (8 * off);
            default:         lanes = 32'hffff_ffff;
        endcase
        return (base & ~lanes) | ((d << (8 * off)) & lanes);
    endfunction

    task automatic note_mismatch(input string what, input word_t expected, input word_t actual);
        errors++;
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        chk_idle |-> (!stall && !req_core && !flush_out && !cache_hit_out
                      && bus_operation_out == BUS_NONE))
        else note_mismatch("idle stall,req,flush,hit,op", 32'h3,
                           32'($sampled({stall, req_core, flush_out, cache_hit_out,
                                         bus_operation_out})));

    // Miss cycles up to and including a load's granted cycle
    miss_stall_held: assert property (@(posedge clk) disable iff (reset)
        chk_wait |-> (stall && req_core))
        else note_mismatch("miss stall,req", 32'h3, 32'($sampled({stall, req_core})));

    bus_op_match: assert property (@(posedge clk) disable iff (reset)
        chk_op |-> (bus_operation_out == exp_op))
        else note_mismatch("bus op", 32'($sampled(exp_op)), 32'($sampled(bus_operation_out)));

    bus_addr_match: assert property (@(posedge clk) disable iff (reset)
        (chk_op && exp_op != BUS_NONE) |-> (bus_address_out == exp_addr))
        else note_mismatch("bus address", $sampled(exp_addr), $sampled(bus_address_out));

    load_data_match: assert property (@(posedge clk) disable iff (reset)
        chk_load |-> (data_out == exp_load))
        else note_mismatch("load data", $sampled(exp_load), $sampled(data_out));

    access_no_stall: assert property (@(posedge clk) disable iff (reset)
        chk_no_stall |-> !stall)
        else note_mismatch("stall", 32'h0, 32'($sampled(stall)));

    snoop_flags_match: assert property (@(posedge clk) disable iff (reset)
        chk_snoop |-> (cache_hit_out == exp_hit && flush_out == exp_flush))
        else note_mismatch("snoop hit,flush", 32'($sampled({exp_hit, exp_flush})),
                           32'($sampled({cache_hit_out, flush_out})));

    snoop_data_match: assert property (@(posedge clk) disable iff (reset)
        chk_snoop |-> (bus_data_out == exp_snoop_data))
        else note_mismatch("snoop data", $sampled(exp_snoop_data), $sampled(bus_data_out));

    task automatic begin_test(input string name);
        @(negedge clk);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        @(posedge clk);
        @(negedge clk);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // One core access with a bus grant after 0 to 3 cycles
    task automatic core_access(input opcode_t op, input mask_t mask, input addr_t addr,
                               input word_t wdata, input int min_delay, input int share_sel);
        index_t  idx;
        bus_op_e op_exp;
        word_t   base;
        logic    shared;
        int      delay;
        idx    = addr[7:2];
        op_exp = BUS_NONE;
        if (sh_state[idx] == MESI_I || sh_tag[idx] != addr[31:8]) begin
            op_exp = (op == OPC_LOAD) ? BUS_RD : BUS_RDX;
        end else if (op == OPC_STORE && sh_state[idx] == MESI_S) begin
            op_exp = BUS_UPGR;
        end
        shared = (share_sel > 1) ? 1'($urandom_range(1, 0)) : 1'(share_sel);
        delay  = $urandom_range(3, min_delay);
        base   = (op_exp == BUS_RD || op_exp == BUS_RDX) ? mem_word(addr) : sh_data[idx];
        @(posedge clk);
        opcode_in    <= op;
        mask_in      <= mask;
        address_in   <= addr;
        data_in      <= wdata;
        chk_op       <= 1'b1;
        exp_op       <= BUS_NONE;
        exp_addr     <= addr;
        chk_load     <= (op == OPC_LOAD && op_exp == BUS_NONE);   // Hit returns at once
        exp_load     <= load_field(base, mask, addr[1:0]);
        chk_no_stall <= (op_exp == BUS_NONE);
        if (op_exp != BUS_NONE) begin
            chk_wait <= (delay > 0);
            for (int n = 0; n < delay; n++) begin
                @(posedge clk);
            end
            chk_wait     <= (op == OPC_LOAD);   // Load fill stays stalled while granted
            grant        <= 1'b1;
            bus_data_in  <= mem_word(addr);
            cache_hit_in <= shared;
            exp_op       <= op_exp;
            chk_no_stall <= (op == OPC_STORE);   // Bus store ends in the granted cycle
            if (op == OPC_LOAD) begin
                @(posedge clk);
                chk_wait     <= 1'b0;
                grant        <= 1'b0;
                cache_hit_in <= 1'b0;
                bus_data_in  <= $urandom;
                exp_op       <= BUS_NONE;
                chk_load     <= 1'b1;             // Filled line hits in the next cycle
                chk_no_stall <= 1'b1;
            end
        end
        @(posedge clk);
        opcode_in    <= OPC_NONE;
        grant        <= 1'b0;
        cache_hit_in <= 1'b0;
        chk_op       <= 1'b0;
        chk_load     <= 1'b0;
        chk_no_stall <= 1'b0;
        if (op_exp == BUS_RD) begin
            sh_state[idx] = shared ? MESI_S : MESI_E;
            sh_tag[idx]   = addr[31:8];
            sh_data[idx]  = base;
        end else if (op == OPC_STORE) begin
            sh_state[idx] = MESI_M;
            sh_tag[idx]   = addr[31:8];
            sh_data[idx]  = merge_store(base, wdata, mask, addr[1:0]);
        end
    endtask

    // Another cache's transaction while the core is idle
    task automatic bus_snoop(input bus_op_e op, input addr_t addr);
        index_t idx;
        logic   hit;
        idx = addr[7:2];
        hit = (sh_state[idx] != MESI_I) && (sh_tag[idx] == addr[31:8]);
        @(posedge clk);
        bus_operation_in <= op;
        bus_address_in   <= addr;
        chk_snoop        <= 1'b1;
        exp_hit          <= hit;
        exp_flush        <= hit && sh_state[idx] == MESI_M && op != BUS_UPGR;
        exp_snoop_data   <= hit ? sh_data[idx] : 32'h0;
        @(posedge clk);
        bus_operation_in <= BUS_NONE;
        chk_snoop        <= 1'b0;
        if (hit) begin
            sh_state[idx] = (op == BUS_RD) ? MESI_S : MESI_I;
        end
    endtask

    initial begin
        addr_t a;
        int    kind;
        mask_t m;
        mask_t masks [5] = '{MASK_B, MASK_H, MASK_W, MASK_BU, MASK_HU};
        void'($urandom(SEED));
        reset            = 1'b1;
        opcode_in        = OPC_NONE;
        mask_in          = MASK_W;
        address_in       = '0;
        data_in          = '0;
        grant            = 1'b0;
        bus_data_in      = '0;
        cache_hit_in     = 1'b0;
        bus_operation_in = BUS_NONE;
        bus_address_in   = '0;
        {chk_idle, chk_wait, chk_op, chk_load, chk_no_stall, chk_snoop} = '0;
        exp_op           = BUS_NONE;
        {exp_addr, exp_load, exp_hit, exp_flush, exp_snoop_data} = '0;
        {errors, errors_at_start, tests, failed} = '0;
        test_name        = "reset";
        for (int i = 0; i < NUM_LINES; i++) begin
            sh_state[i] = MESI_I;
            sh_tag[i]   = '0;
            sh_data[i]  = '0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        begin_test("reset_then_miss");
        @(posedge clk);
        chk_idle <= 1'b1;
        @(posedge clk);
        chk_idle <= 1'b0;
        core_access(OPC_LOAD, MASK_W, 32'h1234_5670, 32'h0, 2, 2);
        end_test();

        begin_test("fill_state");
        core_access(OPC_LOAD, MASK_BU, 32'h0000_a105, 32'h0, 0, 0);            // Exclusive
        core_access(OPC_STORE, MASK_W, 32'h0000_a104, 32'hcafe_f00d, 0, 2);
        core_access(OPC_LOAD, MASK_H, 32'h0000_b20a, 32'h0, 0, 1);             // Shared
        core_access(OPC_STORE, MASK_B, 32'h0000_b209, 32'h0000_005a, 0, 2);
        end_test();

        begin_test("load_masks");
        a = 32'h00c0_ffe0;
        core_access(OPC_STORE, MASK_W, a, 32'h807f_ff01, 0, 2);
        core_access(OPC_STORE, MASK_W, a + 4, 32'h7f80_01ff, 0, 2);
        for (int line = 0; line < 2; line++) begin
            for (int off = 0; off < 4; off++) begin
                core_access(OPC_LOAD, MASK_B, a + 4 * line + off, 32'h0, 0, 2);
                core_access(OPC_LOAD, MASK_BU, a + 4 * line + off, 32'h0, 0, 2);
            end
            for (int off = 0; off < 4; off += 2) begin
                core_access(OPC_LOAD, MASK_H, a + 4 * line + off, 32'h0, 0, 2);
                core_access(OPC_LOAD, MASK_HU, a + 4 * line + off, 32'h0, 0, 2);
            end
            core_access(OPC_LOAD, MASK_W, a + 4 * line, 32'h0, 0, 2);
        end
        end_test();

        begin_test("store_merge");
        a = 32'h0004_5518;
        core_access(OPC_LOAD, MASK_W, a, 32'h0, 0, 0);
        core_access(OPC_STORE, MASK_B, a + 3, 32'h0000_00a5, 0, 2);
        core_access(OPC_STORE, MASK_H, a, 32'h0000_1b2c, 0, 2);
        core_access(OPC_LOAD, MASK_W, a, 32'h0, 0, 2);
        a = 32'h0777_0330;
        core_access(OPC_STORE, MASK_HU, a + 2, 32'hffff_9876, 0, 2);          // BusRdX fill
        core_access(OPC_LOAD, MASK_W, a, 32'h0, 0, 2);
        bus_snoop(BUS_RD, a);                                                 // Flush shows M
        end_test();

        begin_test("snoop");
        a = 32'h0abc_de40;
        core_access(OPC_STORE, MASK_W, a, 32'h1357_9bdf, 0, 2);
        bus_snoop(BUS_RD, a);
        core_access(OPC_STORE, MASK_B, a + 1, 32'h0000_0066, 0, 2);
        bus_snoop(BUS_RDX, a);
        core_access(OPC_LOAD, MASK_W, a, 32'h0, 0, 2);
        bus_snoop(BUS_RD, a ^ 32'h0001_0000);   // Other tag misses
        end_test();

        begin_test("random");
        for (int i = 0; i < 200; i++) begin
            a    = {tag_t'(24'h10 + $urandom_range(2, 0)), index_t'($urandom_range(7, 0)), 2'b00};
            m    = masks[$urandom_range(4, 0)];
            kind = $urandom_range(9, 0);
            if (m == MASK_H || m == MASK_HU) begin
                a = a + 2 * $urandom_range(1, 0);
            end else if (m != MASK_W) begin
                a = a + $urandom_range(3, 0);
            end
            if (kind < 5) begin
                core_access(OPC_LOAD, m, a, 32'h0, 0, 2);
            end else if (kind < 8) begin
                core_access(OPC_STORE, m, a, $urandom, 0, 2);
            end else begin
                bus_snoop((kind == 8) ? BUS_RD : BUS_RDX, a);
            end
        end
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/l1_cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module l1_cache_top
    import l1_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    // Core side
    input  wire opcode_t opcode_in,
    input  wire mask_t   mask_in,
    input  wire addr_t   address_in,
    input  wire word_t   data_in,
    output word_t        data_out,
    output logic         stall,
    output logic         req_core,
    // Arbiter and own bus transaction
    input  wire logic    grant,
    input  wire word_t   bus_data_in,
    input  wire logic    cache_hit_in,
    // Other caches' traffic
    input  wire bus_op_e bus_operation_in,
    input  wire addr_t   bus_address_in,
    output bus_op_e      bus_operation_out,
    output addr_t        bus_address_out,
    output word_t        bus_data_out,
    output logic         cache_hit_out,
    output logic         flush_out
);

    index_t core_index;
    index_t snoop_index;
    mesi_e  core_state;
    tag_t   core_tag;
    word_t  core_data;
    mesi_e  snoop_state;
    tag_t   snoop_tag;
    word_t  snoop_data;

    logic   core_wr_en;
    mesi_e  core_wr_state;
    tag_t   core_wr_tag;
    logic   snoop_wr_en;
    mesi_e  snoop_wr_state;
    tag_t   snoop_wr_tag;
    logic   snoop_busy;
    logic   fill_sel;
    word_t  base_word;
    word_t  store_word;
    word_t  core_wr_data;

    logic   wr_en;
    index_t wr_index;
    mesi_e  wr_state;
    tag_t   wr_tag;
    word_t  wr_data;

    assign core_index  = addr_index(address_in);
    assign snoop_index = addr_index(bus_address_in);

    assign base_word    = fill_sel ? bus_data_in : core_data;
    assign core_wr_data = (opcode_in == OPC_STORE) ? store_word : base_word;   // Fill keeps raw word

    // Snoop downgrade owns the write port when it hits
    assign wr_en    = snoop_wr_en || core_wr_en;
    assign wr_index = snoop_wr_en ? snoop_index    : core_index;
    assign wr_state = snoop_wr_en ? snoop_wr_state : core_wr_state;
    assign wr_tag   = snoop_wr_en ? snoop_wr_tag   : core_wr_tag;
    assign wr_data  = snoop_wr_en ? snoop_data     : core_wr_data;

    cache_array u_array (
        .clk         (clk),
        .reset       (reset),
        .core_index  (core_index),
        .core_state  (core_state),
        .core_tag    (core_tag),
        .core_data   (core_data),
        .snoop_index (snoop_index),
        .snoop_state (snoop_state),
        .snoop_tag   (snoop_tag),
        .snoop_data  (snoop_data),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_state    (wr_state),
        .wr_tag      (wr_tag),
        .wr_data     (wr_data)
    );

    core_ctrl u_core_ctrl (
        .clk               (clk),
        .reset             (reset),
        .opcode_in         (opcode_in),
        .address_in        (address_in),
        .line_state        (core_state),
        .line_tag          (core_tag),
        .grant             (grant),
        .cache_hit_in      (cache_hit_in),
        .snoop_busy        (snoop_busy),
        .stall             (stall),
        .req_core          (req_core),
        .bus_operation_out (bus_operation_out),
        .bus_address_out   (bus_address_out),
        .fill_sel          (fill_sel),
        .wr_en             (core_wr_en),
        .wr_state          (core_wr_state),
        .wr_tag            (core_wr_tag)
    );

    snoop_ctrl u_snoop_ctrl (
        .bus_operation_in (bus_operation_in),
        .bus_address_in   (bus_address_in),
        .line_state       (snoop_state),
        .line_tag         (snoop_tag),
        .line_data        (snoop_data),
        .core_index       (core_index),
        .cache_hit_out    (cache_hit_out),
        .bus_data_out     (bus_data_out),
        .flush_out        (flush_out),
        .snoop_busy       (snoop_busy),
        .wr_en            (snoop_wr_en),
        .wr_state         (snoop_wr_state),
        .wr_tag           (snoop_wr_tag)
    );

    byte_lanes u_lanes (
        .mask_in    (mask_in),
        .offset     (addr_offset(address_in)),
        .base_word  (base_word),
        .data_in    (data_in),
        .store_word (store_word),
        .load_word  (data_out)
    );

endmodule

`default_nettype wire

/* design/core_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module core_ctrl
    import l1_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire opcode_t opcode_in,
    input  wire addr_t   address_in,
    input  wire mesi_e   line_state,   // Array read at the core index
    input  wire tag_t    line_tag,
    input  wire logic    grant,
    input  wire logic    cache_hit_in,
    input  wire logic    snoop_busy,
    output logic         stall,
    output logic         req_core,
    output bus_op_e      bus_operation_out,
    output addr_t        bus_address_out,
    output logic         fill_sel,
    output logic         wr_en,
    output mesi_e        wr_state,
    output tag_t         wr_tag
);

    logic    is_load;
    logic    is_store;
    logic    tag_hit;
    logic    need_bus;
    logic    go;
    bus_op_e bus_op;

    assign is_load  = (opcode_in == OPC_LOAD);
    assign is_store = (opcode_in == OPC_STORE);
    assign tag_hit  = (line_state != MESI_I) && (line_tag == addr_tag(address_in));

    // Bus operation the current access would need
    always_comb begin
        bus_op = BUS_NONE;
        if (is_load && !tag_hit) begin
            bus_op = BUS_RD;
        end else if (is_store && !tag_hit) begin
            bus_op = BUS_RDX;                      // Also covers a tag conflict
        end else if (is_store && line_state == MESI_S) begin
            bus_op = BUS_UPGR;
        end
    end

    assign need_bus = (bus_op != BUS_NONE);
    assign go       = grant && !snoop_busy;        // Bus slot usable this cycle

    assign req_core          = need_bus;
    assign bus_operation_out = go ? bus_op : BUS_NONE;
    assign bus_address_out   = (go && need_bus) ? address_in : '0;

    // Base word from the bus on a load fill or BusRdX
    assign fill_sel = (is_load || is_store) && !tag_hit;

    // A load miss stalls through the fill edge while a bus store ends there
    always_comb begin
        stall = 1'b0;
        if (is_load) begin
            stall = !tag_hit || snoop_busy;
        end else if (is_store) begin
            stall = (need_bus && !go) || snoop_busy;
        end
    end

    // Line update and next MESI state
    always_comb begin
        wr_en    = 1'b0;
        wr_state = line_state;
        if (!snoop_busy) begin
            if (need_bus && grant) begin
                wr_en = 1'b1;
                if (is_store) begin
                    wr_state = MESI_M;
                end else begin
                    wr_state = cache_hit_in ? MESI_S : MESI_E;
                end
            end else if (is_store && tag_hit && !need_bus) begin
                wr_en    = 1'b1;                   // Silent write in E or M
                wr_state = MESI_M;
            end
        end
    end

    assign wr_tag = addr_tag(address_in);

    // Relies on the core holding its request while stalled
    req_held_until_grant: assert property (@(posedge clk) disable iff (reset)
        (req_core && !grant) |=> req_core)
        else $error("core_ctrl: request dropped before grant");

endmodule

`default_nettype wire

/* design/snoop_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module snoop_ctrl
    import l1_pkg::*;
(
    input  wire bus_op_e bus_operation_in,
    input  wire addr_t   bus_address_in,
    input  wire mesi_e   line_state,   // Array read at the snoop index
    input  wire tag_t    line_tag,
    input  wire word_t   line_data,
    input  wire index_t  core_index,
    output logic         cache_hit_out,
    output word_t        bus_data_out,
    output logic         flush_out,
    output logic         snoop_busy,
    output logic         wr_en,
    output mesi_e        wr_state,
    output tag_t         wr_tag
);

    logic tag_match;

    assign tag_match = (line_state != MESI_I) && (line_tag == addr_tag(bus_address_in));

    // Bus side MESI transitions
    always_comb begin
        cache_hit_out = 1'b0;
        flush_out     = 1'b0;
        wr_state      = line_state;
        case (bus_operation_in)
            BUS_RD: begin
                cache_hit_out = tag_match;
                flush_out     = tag_match && (line_state == MESI_M);
                wr_state      = MESI_S;                        // Keep a shared copy
            end
            BUS_UPGR: begin
                cache_hit_out = tag_match;
                wr_state      = MESI_I;
            end
            BUS_RDX: begin
                cache_hit_out = tag_match;
                flush_out     = tag_match && (line_state == MESI_M);
                wr_state      = MESI_I;
            end
            default: begin
                cache_hit_out = 1'b0;                          // Idle bus
            end
        endcase
    end

    assign bus_data_out = cache_hit_out ? line_data : '0;

    // Downgrade rewrites the line with its own tag and data
    assign wr_en  = cache_hit_out;
    assign wr_tag = line_tag;

    // Core access to the same line waits one cycle
    assign snoop_busy = cache_hit_out && (addr_index(bus_address_in) == core_index);

endmodule

`default_nettype wire

/* design/byte_lanes.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_lanes
    import l1_pkg::*;
(
    input  wire mask_t   mask_in,
    input  wire offset_t offset,
    input  wire word_t   base_word,   // Line word or bus word on a fill
    input  wire word_t   data_in,
    output word_t        store_word,
    output word_t        load_word
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // Field selection by offset
    always_comb begin
        case (offset)
            2'd0:    load_byte = base_word[7:0];
            2'd1:    load_byte = base_word[15:8];
            2'd2:    load_byte = base_word[23:16];
            default: load_byte = base_word[31:24];
        endcase
        load_half = offset[1] ? base_word[31:16] : base_word[15:0];
    end

    always_comb begin
        case (mask_in)
            MASK_B:  load_word = {{24{load_byte[7]}}, load_byte};
            MASK_BU: load_word = {24'b0, load_byte};
            MASK_H:  load_word = {{16{load_half[15]}}, load_half};
            MASK_HU: load_word = {16'b0, load_half};
            MASK_W:  load_word = base_word;
            default: load_word = '0;   // Reserved size codes
        endcase
    end

    // Store merge, the unsigned codes act as their signed pairs
    always_comb begin
        store_word = base_word;
        case (mask_in)
            MASK_B, MASK_BU: begin
                case (offset)
                    2'd0:    store_word[7:0]   = data_in[7:0];
                    2'd1:    store_word[15:8]  = data_in[7:0];
                    2'd2:    store_word[23:16] = data_in[7:0];
                    default: store_word[31:24] = data_in[7:0];
                endcase
            end
            MASK_H, MASK_HU: begin
                if (offset[1]) begin
                    store_word[31:16] = data_in[15:0];
                end else begin
                    store_word[15:0] = data_in[15:0];
                end
            end
            MASK_W: begin
                store_word = data_in;
            end
            default: begin
                store_word = base_word;   // Line left untouched
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/cache_array.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_array
    import l1_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    // Core side read
    input  wire index_t core_index,
    output mesi_e       core_state,
    output tag_t        core_tag,
    output word_t       core_data,
    // Snoop side read
    input  wire index_t snoop_index,
    output mesi_e       snoop_state,
    output tag_t        snoop_tag,
    output word_t       snoop_data,
    // Shared write port
    input  wire logic   wr_en,
    input  wire index_t wr_index,
    input  wire mesi_e  wr_state,
    input  wire tag_t   wr_tag,
    input  wire word_t  wr_data
);

    mesi_e state_mem [NUM_LINES];
    tag_t  tag_mem   [NUM_LINES];
    word_t data_mem  [NUM_LINES];

    // Only the state needs clearing, Invalid lines ignore tag and data
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                state_mem[i] <= MESI_I;
            end
        end else if (wr_en) begin
            state_mem[wr_index] <= wr_state;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= wr_data;
        end
    end

    assign core_state  = state_mem[core_index];
    assign core_tag    = tag_mem[core_index];
    assign core_data   = data_mem[core_index];

    assign snoop_state = state_mem[snoop_index];
    assign snoop_tag   = tag_mem[snoop_index];
    assign snoop_data  = data_mem[snoop_index];

    // Write index comes from either controller through the top mux
    wr_index_known: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_index))
        else $error("cache_array: write with unknown index");

endmodule

`default_nettype wire

/* design/l1_pkg.sv */
`default_nettype none

package l1_pkg;

    // Fixed address split: tag 31:8, index 7:2, byte 1:0
    localparam int NUM_LINES = 64;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [23:0] tag_t;
    typedef logic [5:0]  index_t;
    typedef logic [1:0]  offset_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  mask_t;

    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    // Access size, bit 2 set means zero extension on loads
    localparam mask_t MASK_B  = 3'b000;
    localparam mask_t MASK_H  = 3'b001;
    localparam mask_t MASK_W  = 3'b010;
    localparam mask_t MASK_BU = 3'b100;
    localparam mask_t MASK_HU = 3'b101;

    typedef enum logic [1:0] {
        MESI_I = 2'b00,
        MESI_E = 2'b01,
        MESI_S = 2'b10,
        MESI_M = 2'b11
    } mesi_e;

    typedef enum logic [1:0] {
        BUS_RD   = 2'b00,
        BUS_UPGR = 2'b01,
        BUS_RDX  = 2'b10,
        BUS_NONE = 2'b11   // Idle bus slot
    } bus_op_e;

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[31:8];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[7:2];
    endfunction

    function automatic offset_t addr_offset(input addr_t addr);
        return addr[1:0];
    endfunction

endpackage

`default_nettype wire
